// ==== hdl/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module aluUnit import mipsPkg::*; (
    input  ctrlT               ctrl,
    input  instrFieldsT        fields,
    input  logic [`WORD_W-1:0] opA,
    input  logic [`WORD_W-1:0] opB,
    output logic [`WORD_W-1:0] result,
    output logic               equal
);

    logic [`WORD_W-1:0] immExt;
    logic [`WORD_W-1:0] shamtExt;
    logic [`WORD_W-1:0] opSel;

    assign immExt   = {{(`WORD_W-`IMM_W){fields.imm16[`IMM_W-1]}}, fields.imm16};
    assign shamtExt = {{(`WORD_W-`SHAMT_W){1'b0}}, fields.shamt};

    always_comb begin
        case (ctrl.aluSrc)
            srcImm:   opSel = immExt;
            srcShamt: opSel = shamtExt;
            default:  opSel = opB;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: result = opA + opSel;
            aluSub: result = opA - opSel;
            aluAnd: result = opA & opSel;
            aluOr:  result = opA | opSel;
            // signed compare
            aluSlt: result = {{(`WORD_W-1){1'b0}}, $signed(opA) < $signed(opSel)};
            aluSll: result = opA << opSel[`SHAMT_W-1:0];
            aluSrl: result = opA >> opSel[`SHAMT_W-1:0];
            default: result = '0;
        endcase
    end

    // branch compare, rs against rt
    assign equal = (opA == opSel);

endmodule

`default_nettype wire

// ==== hdl/execSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module execSequencer import mipsPkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  ctrlT ctrl,
    input  logic fetchDone,
    input  logic dataDone,
    output logic fetchStart,
    output logic dataStart,
    output logic irLoad,
    output logic commit
);

    typedef enum logic [2:0] {
        Fetch,
        WaitFetch,
        Execute,
        WaitData,
        Commit
    } seqStateT;

    seqStateT state;
    seqStateT stateNext;
    logic     memAccess;

    assign memAccess = ctrl.memRead || ctrl.memWrite;

    always_comb begin
        stateNext = state;
        case (state)
            Fetch:     stateNext = WaitFetch;
            WaitFetch: begin
                if (fetchDone) begin
                    stateNext = Execute;
                end
            end
            // one cycle, then either a data access or commit
            Execute:   stateNext = memAccess ? WaitData : Commit;
            WaitData: begin
                if (dataDone) begin
                    stateNext = Commit;
                end
            end
            Commit:    stateNext = Fetch;
            default:   stateNext = Fetch;
        endcase
    end

    // Fetch is the reset state so the first fetch starts on release
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state <= Fetch;
        end else begin
            state <= stateNext;
        end
    end

    assign fetchStart = (state == Fetch);
    assign irLoad     = (state == WaitFetch) && fetchDone;
    assign dataStart  = (state == Execute) && memAccess;
    assign commit     = (state == Commit);

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module instrDecoder import mipsPkg::*; (
    input  logic [`WORD_W-1:0] instr,
    output instrFieldsT        fields,
    output ctrlT               ctrl
);

    // split the word up for every format
    always_comb begin
        fields.op     = instr[31:26];
        fields.rs     = instr[25:21];
        fields.rt     = instr[20:16];
        fields.rd     = instr[15:11];
        fields.shamt  = instr[10:6];
        fields.funct  = instr[5:0];
        fields.imm16  = instr[15:0];
        fields.addr26 = instr[25:0];
    end

    always_comb begin
        // no-op unless an opcode below says otherwise
        ctrl        = '0;
        ctrl.aluSrc = srcReg;
        ctrl.aluOp  = aluAdd;
        case (fields.op)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (fields.funct)
                    `FUNCT_ADD: ctrl.aluOp = aluAdd;
                    `FUNCT_SUB: ctrl.aluOp = aluSub;
                    `FUNCT_AND: ctrl.aluOp = aluAnd;
                    `FUNCT_OR:  ctrl.aluOp = aluOr;
                    `FUNCT_SLT: ctrl.aluOp = aluSlt;
                    `FUNCT_SLL: begin
                        ctrl.aluOp  = aluSll;
                        ctrl.aluSrc = srcShamt;
                    end
                    `FUNCT_SRL: begin
                        ctrl.aluOp  = aluSrl;
                        ctrl.aluSrc = srcShamt;
                    end
                    `FUNCT_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.regDstRd = 1'b0;
                    end
                endcase
            end
            `OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            `OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            `OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            `OP_J: ctrl.jump = 1'b1;
            `OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.linkRa   = 1'b1;
            end
            `OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            `OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/memPort.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module memPort import mipsPkg::*; #(
    parameter type reqT = fetchReqT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  reqT                reqIn,
    input  logic               ack,
    input  logic [`WORD_W-1:0] rdata,
    output logic               req,
    output reqT                reqOut,
    output logic               done,
    output logic [`WORD_W-1:0] rsp
);

    typedef enum logic [1:0] {
        Idle,
        ReqHigh,
        AckLow
    } portStateT;

    portStateT state;

    // four-phase sequence, req follows the state
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state <= Idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                Idle: begin
                    if (start) begin
                        state <= ReqHigh;
                    end
                end
                ReqHigh: begin
                    if (ack) begin
                        state <= AckLow;
                    end
                end
                AckLow: begin
                    // slave has released, transfer complete
                    if (!ack) begin
                        done  <= 1'b1;
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    assign req = (state == ReqHigh);

    // payload held from start until the next start
    always_ff @(posedge clk) begin
        if (state == Idle && start) begin
            reqOut <= reqIn;
        end
        if (state == ReqHigh && ack) begin
            rsp <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mipsCore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module mipsCore import mipsPkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    output logic               imemReq,
    output fetchReqT           imemReqData,
    input  logic               imemAck,
    input  logic [`WORD_W-1:0] imemRdata,
    output logic               dmemReq,
    output dataReqT            dmemReqData,
    input  logic               dmemAck,
    input  logic [`WORD_W-1:0] dmemRdata
);

    logic                   fetchStart;
    logic                   dataStart;
    logic                   irLoad;
    logic                   commit;
    logic                   fetchDone;
    logic                   dataDone;
    logic [`WORD_W-1:0]     fetchRsp;
    logic [`WORD_W-1:0]     dataRsp;
    logic [`WORD_W-1:0]     instrReg;
    instrFieldsT            fields;
    ctrlT                   ctrl;
    logic [`WORD_W-1:0]     pc;
    logic [`WORD_W-1:0]     pcPlus4;
    logic [`REG_ADDR_W-1:0] raddrA;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`WORD_W-1:0]     wdata;
    logic                   regWe;
    logic [`WORD_W-1:0]     rdataA;
    logic [`WORD_W-1:0]     rdataB;
    logic [`WORD_W-1:0]     aluResult;
    logic                   aluEqual;
    fetchReqT               fetchReq;
    dataReqT                dataReq;

    execSequencer sequencer (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .fetchDone(fetchDone), .dataDone(dataDone),
        .fetchStart(fetchStart), .dataStart(dataStart), .irLoad(irLoad), .commit(commit)
    );

    memPort #(.reqT(fetchReqT)) fetchPort (
        .clk(clk), .rst_n(rst_n), .start(fetchStart), .reqIn(fetchReq), .ack(imemAck),
        .rdata(imemRdata), .req(imemReq), .reqOut(imemReqData), .done(fetchDone),
        .rsp(fetchRsp)
    );

    memPort #(.reqT(dataReqT)) dataPort (
        .clk(clk), .rst_n(rst_n), .start(dataStart), .reqIn(dataReq), .ack(dmemAck),
        .rdata(dmemRdata), .req(dmemReq), .reqOut(dmemReqData), .done(dataDone),
        .rsp(dataRsp)
    );

    // instruction held for execute and commit, zero decodes as a no-op
    always_ff @(posedge clk) begin
        if (rst_n) begin
            instrReg <= '0;
        end else if (irLoad) begin
            instrReg <= fetchRsp;
        end
    end

    instrDecoder decoder (.instr(instrReg), .fields(fields), .ctrl(ctrl));

    // shifts read rt on port A
    assign raddrA = (ctrl.aluSrc == srcShamt) ? fields.rt : fields.rs;
    assign waddr  = ctrl.regDstRd ? fields.rd : (ctrl.linkRa ? `RA_REG : fields.rt);
    assign wdata  = ctrl.memToReg ? dataRsp : (ctrl.linkRa ? pcPlus4 : aluResult);
    assign regWe  = commit && ctrl.regWrite;

    regFile regs (
        .clk(clk), .rst_n(rst_n), .raddrA(raddrA), .raddrB(fields.rt), .waddr(waddr),
        .we(regWe), .wdata(wdata), .rdataA(rdataA), .rdataB(rdataB)
    );

    aluUnit alu (
        .ctrl(ctrl), .fields(fields), .opA(rdataA), .opB(rdataB),
        .result(aluResult), .equal(aluEqual)
    );

    programCounter pcUnit (
        .clk(clk), .rst_n(rst_n), .commit(commit), .ctrl(ctrl), .fields(fields),
        .rsValue(rdataA), .aluEqual(aluEqual), .pc(pc), .pcPlus4(pcPlus4)
    );

    assign fetchReq.addr = pc;

    // word address from the byte address
    assign dataReq.write = ctrl.memWrite;
    assign dataReq.addr  = aluResult[`DMEM_ADDR_W+1:2];
    assign dataReq.wdata = rdataB;

endmodule

`default_nettype wire

// ==== hdl/mipsCore_defs.svh ====
`ifndef MIPSCORE_DEFS_SVH
`define MIPSCORE_DEFS_SVH

// datapath widths
`define WORD_W       32
`define REG_ADDR_W   5
`define DMEM_ADDR_W  7

// instruction field widths
`define OPCODE_W     6
`define FUNCT_W      6
`define SHAMT_W      5
`define IMM_W        16
`define JADDR_W      26

// opcodes
`define OP_RTYPE     6'h00
`define OP_J         6'h02
`define OP_JAL       6'h03
`define OP_BEQ       6'h04
`define OP_BNE       6'h05
`define OP_ADDI      6'h08
`define OP_LW        6'h23
`define OP_SW        6'h2B

// function codes for R-type
`define FUNCT_SLL    6'h00
`define FUNCT_SRL    6'h02
`define FUNCT_JR     6'h08
`define FUNCT_ADD    6'h20
`define FUNCT_SUB    6'h22
`define FUNCT_AND    6'h24
`define FUNCT_OR     6'h25
`define FUNCT_SLT    6'h2A

// link register for jal
`define RA_REG       5'd31

`endif

// ==== hdl/mipsPkg.sv ====
`default_nettype none

`include "mipsCore_defs.svh"

package mipsPkg;

    // fields overlap in the instruction word, so this is wider than 32 bits
    typedef struct packed {
        logic [`OPCODE_W-1:0]   op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`SHAMT_W-1:0]    shamt;
        logic [`FUNCT_W-1:0]    funct;
        logic [`IMM_W-1:0]      imm16;
        logic [`JADDR_W-1:0]    addr26;
    } instrFieldsT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluSrl
    } aluOpT;

    // second ALU operand source
    typedef enum logic [1:0] {
        srcReg,
        srcImm,
        srcShamt
    } aluSrcT;

    typedef struct packed {
        logic   regWrite;
        logic   regDstRd;
        logic   linkRa;
        logic   memToReg;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   branchNe;
        logic   jump;
        logic   jumpReg;
        aluSrcT aluSrc;
        aluOpT  aluOp;
    } ctrlT;

    // byte address, word aligned
    typedef struct packed {
        logic [`WORD_W-1:0] addr;
    } fetchReqT;

    typedef struct packed {
        logic                    write;
        logic [`DMEM_ADDR_W-1:0] addr;
        logic [`WORD_W-1:0]      wdata;
    } dataReqT;

endpackage

`default_nettype wire

// ==== hdl/programCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module programCounter import mipsPkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               commit,
    input  ctrlT               ctrl,
    input  instrFieldsT        fields,
    input  logic [`WORD_W-1:0] rsValue,
    input  logic               aluEqual,
    output logic [`WORD_W-1:0] pc,
    output logic [`WORD_W-1:0] pcPlus4
);

    logic [`WORD_W-1:0] jumpTarget;
    logic [`WORD_W-1:0] branchOffset;
    logic [`WORD_W-1:0] branchTarget;
    logic [`WORD_W-1:0] pcNext;
    logic               branchTaken;

    assign pcPlus4      = pc + `WORD_W'(4);
    assign jumpTarget   = {pcPlus4[`WORD_W-1 -: 4], fields.addr26, 2'b00};
    assign branchOffset = {{(`WORD_W-`IMM_W-2){fields.imm16[`IMM_W-1]}}, fields.imm16, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // bne takes the branch on a mismatch
    assign branchTaken = ctrl.branch && (aluEqual != ctrl.branchNe);

    always_comb begin
        if (ctrl.jump) begin
            pcNext = jumpTarget;
        end else if (ctrl.jumpReg) begin
            pcNext = rsValue;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= '0;
        end else if (commit) begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] raddrA,
    input  logic [`REG_ADDR_W-1:0] raddrB,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic                   we,
    input  logic [`WORD_W-1:0]     wdata,
    output logic [`WORD_W-1:0]     rdataA,
    output logic [`WORD_W-1:0]     rdataB
);

    localparam int NumRegs = 1 << `REG_ADDR_W;

    logic [`WORD_W-1:0] regs [NumRegs];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // register 0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

`default_nettype wire

// ==== mipsCore.f ====
+incdir+hdl
hdl/mipsPkg.sv
hdl/instrDecoder.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/programCounter.sv
hdl/memPort.sv
hdl/execSequencer.sv
hdl/mipsCore.sv
test/mipsCore_props.sv
test/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mipsCoreTb \
    -f mipsCore.f -Mdir obj_dir

output=$(./obj_dir/VmipsCoreTb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== test/mipsCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCore_defs.svh"

module mipsCoreTb import mipsPkg::*; ();

    localparam int MaxCyclesPerInstr = 32;
    localparam int ImemWords = 64;

    logic               clk;
    logic               rst_n;
    logic               imemReq;
    fetchReqT           imemReqData;
    logic               imemAck = 1'b0;
    logic [`WORD_W-1:0] imemRdata = '0;
    logic               dmemReq;
    dataReqT            dmemReqData;
    logic               dmemAck = 1'b0;
    logic [`WORD_W-1:0] dmemRdata = '0;

    logic [`WORD_W-1:0] imem [ImemWords];
    logic [`WORD_W-1:0] dmem [1 << `DMEM_ADDR_W];
    logic [`WORD_W-1:0] fetchLog [$];
    dataReqT            dataLog [$];
    logic [`WORD_W-1:0] haltAddr;
    logic               halted;
    logic               randomAcks;
    logic               fetchSeen = 1'b0;
    logic               dataSeen = 1'b0;
    logic               watchArmed;
    integer             seed;
    int                 progLen;
    int                 fetchWait;
    int                 dataWait;
    int                 watchCycles;
    int                 watchLimit;
    string              currentTest;

    mipsCore uut (
        .clk(clk), .rst_n(rst_n), .imemReq(imemReq), .imemReqData(imemReqData),
        .imemAck(imemAck), .imemRdata(imemRdata), .dmemReq(dmemReq),
        .dmemReqData(dmemReqData), .dmemAck(dmemAck), .dmemRdata(dmemRdata)
    );

    bind memPort mipsCore_props #(.reqT(reqT)) handshakeProps (
        .clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .reqOut(reqOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input int shamt, input logic [5:0] funct);
        return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // target is a byte address
    function automatic logic [31:0] jType(input logic [5:0] op, input int target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] fillWord(input int index);
        logic [31:0] w;
        w = index;
        return 32'h9E3779B9 ^ (w * 32'h00010203);
    endfunction

    function automatic int ackDelay();
        int r;
        if (!randomAcks) begin
            return 0;
        end
        r = $random(seed);
        return r & 3;
    endfunction

    // instruction memory slave that logs every fetch address
    always @(negedge clk) begin
        if (rst_n) begin
            imemAck = 1'b0;
            fetchSeen = 1'b0;
            fetchWait = 0;
        end else if (imemReq && !imemAck) begin
            if (!fetchSeen) begin
                fetchSeen = 1'b1;
                fetchWait = ackDelay();
                fetchLog.push_back(imemReqData.addr);
                if (imemReqData.addr == haltAddr) begin
                    halted = 1'b1;
                end
            end
            if (fetchWait > 0) begin
                fetchWait--;
            end else begin
                imemAck = 1'b1;
                imemRdata = imem[imemReqData.addr[7:2]];
                fetchWait = ackDelay();
            end
        end else if (!imemReq && imemAck) begin
            if (fetchWait > 0) begin
                fetchWait--;
            end else begin
                imemAck = 1'b0;
                fetchSeen = 1'b0;
            end
        end
    end

    // data memory slave that logs every request
    always @(negedge clk) begin
        if (rst_n) begin
            dmemAck = 1'b0;
            dataSeen = 1'b0;
            dataWait = 0;
        end else if (dmemReq && !dmemAck) begin
            if (!dataSeen) begin
                dataSeen = 1'b1;
                dataWait = ackDelay();
                dataLog.push_back(dmemReqData);
            end
            if (dataWait > 0) begin
                dataWait--;
            end else begin
                dmemAck = 1'b1;
                if (dmemReqData.write) begin
                    dmem[dmemReqData.addr] = dmemReqData.wdata;
                end else begin
                    dmemRdata = dmem[dmemReqData.addr];
                end
                dataWait = ackDelay();
            end
        end else if (!dmemReq && dmemAck) begin
            if (dataWait > 0) begin
                dataWait--;
            end else begin
                dmemAck = 1'b0;
                dataSeen = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (watchArmed) begin
            watchCycles++;
            if (watchCycles > watchLimit) begin
                $display("%s: the core hung, no halt loop within %0d cycles",
                         currentTest, watchLimit);
                $display("TEST RESULT: FAIL");
                $fatal(1, "watchdog expired");
            end
        end
    end

    task automatic checkValues(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compareRequest(input string name, input int idx, input logic expWrite,
                                  input int expAddr, input logic [31:0] expData);
        checkValues($sformatf("%s request %0d write flag", name, idx),
                    32'(expWrite), 32'(dataLog[idx].write));
        checkValues($sformatf("%s request %0d address", name, idx),
                    expAddr, 32'(dataLog[idx].addr));
        if (expWrite) begin
            checkValues($sformatf("%s request %0d data", name, idx), expData,
                        dataLog[idx].wdata);
        end
    endtask

    task automatic newProgram();
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = '0;
        end
        progLen = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // halt is a beq onto itself
    task automatic finishProgram();
        haltAddr = progLen * 4;
        emit(iType(`OP_BEQ, 0, 0, -1));
    endtask

    task automatic resetCore();
        @(negedge clk);
        rst_n = 1'b1;
        halted = 1'b0;
        fetchLog.delete();
        dataLog.delete();
        repeat (3) begin
            @(negedge clk);
            checkValues("reset imemReq", 32'h0, 32'(imemReq));
            checkValues("reset dmemReq", 32'h0, 32'(dmemReq));
        end
        rst_n = 1'b0;
    endtask

    task automatic runProgram(input string name, input int instrs);
        currentTest = name;
        watchLimit = (instrs + 2) * MaxCyclesPerInstr;
        resetCore();
        watchCycles = 0;
        watchArmed = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        watchArmed = 1'b0;
    endtask

    task automatic resetAndFirstFetch();
        newProgram();
        finishProgram();
        runProgram("reset", 1);
        checkValues("reset first fetch address", 32'h0, fetchLog[0]);
    endtask

    task automatic arithStores(input string name);
        int          storeRegs [8] = '{3, 4, 5, 6, 7, 8, 10, 0};
        logic [31:0] expected [8];
        int          a;
        int          b;
        int          c;
        a = 25;
        b = -7;
        c = -3;
        newProgram();
        emit(iType(`OP_ADDI, 0, 1, a));
        emit(iType(`OP_ADDI, 0, 2, b));
        emit(iType(`OP_ADDI, 0, 9, c));
        emit(rType(1, 2, 3, 0, `FUNCT_ADD));
        emit(rType(2, 1, 4, 0, `FUNCT_SUB));
        emit(rType(1, 2, 5, 0, `FUNCT_AND));
        emit(rType(1, 2, 6, 0, `FUNCT_OR));
        emit(rType(2, 1, 7, 0, `FUNCT_SLT));
        emit(rType(1, 2, 8, 0, `FUNCT_SLT));
        emit(rType(2, 9, 10, 0, `FUNCT_SLT));
        // register 0 must ignore this
        emit(iType(`OP_ADDI, 0, 0, 99));
        for (int i = 0; i < 8; i++) begin
            emit(iType(`OP_SW, 0, storeRegs[i], 4 * i));
        end
        finishProgram();
        expected = '{a + b, b - a, a & b, a | b, int'(b < a), int'(a < b), int'(b < c), 0};
        runProgram(name, progLen);
        checkValues({name, " request count"}, 8, dataLog.size());
        for (int i = 0; i < 8; i++) begin
            compareRequest(name, i, 1'b1, i, expected[i]);
        end
    endtask

    task automatic shiftStores(input string name);
        int          shamts [6] = '{0, 4, 17, 3, 31, 9};
        logic [31:0] expected [6];
        logic [31:0] v;
        v = 32'h5A3C;
        newProgram();
        emit(iType(`OP_ADDI, 0, 1, v));
        emit(rType(0, 1, 2, shamts[0], `FUNCT_SLL));
        emit(rType(0, 1, 3, shamts[1], `FUNCT_SLL));
        emit(rType(0, 1, 4, shamts[2], `FUNCT_SLL));
        emit(rType(0, 4, 5, shamts[3], `FUNCT_SRL));
        emit(rType(0, 4, 6, shamts[4], `FUNCT_SRL));
        emit(rType(0, 1, 7, shamts[5], `FUNCT_SRL));
        for (int i = 0; i < 6; i++) begin
            emit(iType(`OP_SW, 0, 2 + i, 32 + 4 * i));
        end
        finishProgram();
        expected = '{v, v << 4, v << 17, (v << 17) >> 3, (v << 17) >> 31, v >> 9};
        runProgram(name, progLen);
        checkValues({name, " request count"}, 6, dataLog.size());
        for (int i = 0; i < 6; i++) begin
            compareRequest(name, i, 1'b1, 8 + i, expected[i]);
        end
    endtask

    task automatic loadThenStore(input string name);
        int loadOff [3] = '{0, 4, 8};
        int storeOff [3] = '{0, 4, -4};
        int loadBase;
        int storeBase;
        loadBase = 160;
        storeBase = 200;
        for (int i = 0; i < (1 << `DMEM_ADDR_W); i++) begin
            dmem[i] = fillWord(i);
        end
        newProgram();
        emit(iType(`OP_ADDI, 0, 10, loadBase));
        for (int i = 0; i < 3; i++) begin
            emit(iType(`OP_LW, 10, 1 + i, loadOff[i]));
        end
        emit(iType(`OP_ADDI, 0, 11, storeBase));
        for (int i = 0; i < 3; i++) begin
            emit(iType(`OP_SW, 11, 1 + i, storeOff[i]));
        end
        finishProgram();
        runProgram(name, progLen);
        checkValues({name, " request count"}, 6, dataLog.size());
        for (int i = 0; i < 3; i++) begin
            compareRequest(name, i, 1'b0, (loadBase + loadOff[i]) >> 2, '0);
            compareRequest(name, 3 + i, 1'b1, (storeBase + storeOff[i]) >> 2,
                           fillWord((loadBase + loadOff[i]) >> 2));
            checkValues({name, " stored word"}, fillWord((loadBase + loadOff[i]) >> 2),
                        dmem[(storeBase + storeOff[i]) >> 2]);
        end
    endtask

    task automatic branchAndJump(input string name);
        int expFetch [14] = '{0, 4, 8, 16, 20, 24, 32, 36, 44, 56, 60, 48, 52, 64};
        newProgram();
        emit(iType(`OP_ADDI, 0, 1, 5));
        emit(iType(`OP_ADDI, 0, 2, 5));
        emit(iType(`OP_BEQ, 1, 2, 1));
        emit(iType(`OP_ADDI, 0, 9, 1));
        emit(iType(`OP_BNE, 1, 2, 1));
        emit(iType(`OP_ADDI, 0, 3, 7));
        emit(iType(`OP_BNE, 1, 3, 1));
        emit(iType(`OP_ADDI, 0, 9, 2));
        emit(iType(`OP_BEQ, 1, 3, 1));
        emit(jType(`OP_J, 44));
        emit(iType(`OP_ADDI, 0, 9, 3));
        emit(jType(`OP_JAL, 56));
        // return point of the subroutine at 56
        emit(iType(`OP_SW, 0, 9, 100));
        emit(jType(`OP_J, 64));
        emit(iType(`OP_SW, 0, 31, 104));
        emit(rType(31, 0, 0, 0, `FUNCT_JR));
        finishProgram();
        runProgram(name, 14);
        checkValues({name, " fetch count"}, 14, fetchLog.size());
        for (int i = 0; i < 14; i++) begin
            checkValues($sformatf("%s fetch %0d", name, i), expFetch[i], fetchLog[i]);
        end
        checkValues({name, " request count"}, 2, dataLog.size());
        compareRequest(name, 0, 1'b1, 104 >> 2, 44 + 4);
        compareRequest(name, 1, 1'b1, 100 >> 2, 0);
    endtask

    initial begin
        rst_n = 1'b1;
        seed = 78855;
        randomAcks = 1'b0;
        watchArmed = 1'b0;
        watchCycles = 0;
        watchLimit = 0;
        halted = 1'b0;
        haltAddr = '0;
        progLen = 0;

        resetAndFirstFetch();
        arithStores("arith");
        shiftStores("shift");
        loadThenStore("load store");
        branchAndJump("control");

        // same programs with slow, uneven slaves
        randomAcks = 1'b1;
        arithStores("arith random acks");
        shiftStores("shift random acks");
        loadThenStore("load store random acks");
        branchAndJump("control random acks");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/mipsCore_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsCore_props #(
    parameter type reqT = logic
) (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input reqT  reqOut
);

    // req only drops once the slave has answered
    reqHoldsUntilAck: assert property (
        @(posedge clk) disable iff (rst_n) $fell(req) |-> $past(ack)
    ) else $error("req fell before ack rose");

    payloadStable: assert property (
        @(posedge clk) disable iff (rst_n) (req && $past(req)) |-> $stable(reqOut)
    ) else $error("request payload changed while req was high");

    // a new request waits for the slave to release ack
    noRiseDuringAck: assert property (
        @(posedge clk) disable iff (rst_n) $rose(req) |-> !$past(ack)
    ) else $error("req rose while ack was still high");

    reqLowAfterReset: assert property (
        @(posedge clk) rst_n |=> !req
    ) else $error("req high right after reset");

endmodule

`default_nettype wire
